/* sim.f */
+incdir+tests
src/id_pkg.sv
src/id_ctrl_if.sv
src/instr_decoder.sv
src/reg_file.sv
src/id_ex_reg.sv
src/id_stage.sv
tests/tb_id_stage.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_id_stage -f sim.f -Mdir obj_dir &&
./obj_dir/Vtb_id_stage || exit 1

/* tests/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_q = 32'h9b3a8d2f;

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        r      = {r[30:0], fb};
    end
    return r;
endfunction

function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_bits(32);
    lo = rand_bits(32);
    return {hi, lo};
endfunction

// R-type field layout
function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] op);
    return {f7, rs2, rs1, f3, rd, op, 2'b11};
endfunction

// random upper 25 bits under a fixed opcode
function automatic logic [31:0] rand_instr(input logic [4:0] op);
    logic [31:0] bits;
    bits = rand_bits(25);
    return {bits[24:0], op, 2'b11};
endfunction

// immediates as laid out in the ISA manual
function automatic logic [63:0] exp_imm(input id_pkg::imm_fmt_e fmt, input logic [31:0] ins);
    logic [11:0] i_v;
    logic [11:0] s_v;
    logic [12:0] b_v;
    logic [20:0] j_v;
    i_v = ins[31:20];
    s_v = {ins[31:25], ins[11:7]};
    b_v = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    j_v = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    case (fmt)
        id_pkg::IMM_I: return {{52{i_v[11]}}, i_v};
        id_pkg::IMM_S: return {{52{s_v[11]}}, s_v};
        id_pkg::IMM_B: return {{51{b_v[12]}}, b_v};
        id_pkg::IMM_U: return {{32{ins[31]}}, ins[31:12], 12'h000};
        id_pkg::IMM_J: return {{43{j_v[20]}}, j_v};
        default:       return 64'd0;
    endcase
endfunction

// base operation first, then the word variant where one exists
function automatic id_pkg::alu_op_e exp_alu(input logic [4:0] op, input logic [2:0] f3,
                                            input logic [6:0] f7);
    logic            word;
    logic            sub;
    id_pkg::alu_op_e res;
    word = (op == id_pkg::OP_REG_32) || (op == id_pkg::OP_IMM_32);
    sub  = f7[5] && ((op == id_pkg::OP_REG) || (op == id_pkg::OP_REG_32));
    case (f3)
        3'b000:  res = sub ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
        3'b001:  res = id_pkg::ALU_SLL;
        3'b010:  res = id_pkg::ALU_SLT;
        3'b011:  res = id_pkg::ALU_SLTU;
        3'b100:  res = id_pkg::ALU_XOR;
        3'b101:  res = f7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
        3'b110:  res = id_pkg::ALU_OR;
        default: res = id_pkg::ALU_AND;
    endcase
    if (word) begin
        case (res)
            id_pkg::ALU_ADD: res = id_pkg::ALU_ADDW;
            id_pkg::ALU_SUB: res = id_pkg::ALU_SUBW;
            id_pkg::ALU_SLL: res = id_pkg::ALU_SLLW;
            id_pkg::ALU_SRL: res = id_pkg::ALU_SRLW;
            id_pkg::ALU_SRA: res = id_pkg::ALU_SRAW;
            default:         res = res;
        endcase
    end
    return res;
endfunction

`endif

/* tests/tb_id_stage.sv */
module tb_id_stage;
    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              rst_n_i;
    logic              valid_i;
    logic              ready_o;
    logic [63:0]       pc_i;
    logic [31:0]       instr_i;
    logic              wb_en_i;
    logic [4:0]        wb_rd_i;
    logic [63:0]       wb_data_i;
    logic              ready_i;
    logic              valid_o;
    logic [63:0]       pc_o;
    logic [63:0]       rs1_o;
    logic [63:0]       rs2_o;
    logic [63:0]       imm_o;
    id_pkg::alu_op_e   alu_op_o;
    id_pkg::src1_sel_e src1_sel_o;
    id_pkg::src2_sel_e src2_sel_o;
    logic [4:0]        rd_o;
    logic              wb_en_o;
    logic              is_load_o;
    logic              is_jal_o;
    logic              is_jalr_o;
    logic              is_brc_o;
    logic              div_en_o;
    logic [2:0]        div_sel_o;
    logic              trap_o;
    logic              trap_in_o;
    logic              trap_out_o;

    // register contents as the writeback port left them
    logic [63:0] exp_regs [32];

    `include "tb_ref_model.svh"

    id_stage u_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        $display("TEST FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // hold the instruction until an edge accepts it
    task automatic send(input logic [31:0] instr, input logic [63:0] pc);
        int n;
        n       = 0;
        valid_i = 1'b1;
        instr_i = instr;
        pc_i    = pc;
        @(negedge clk);
        while (!ready_o) begin
            n++;
            if (n > 50) begin
                timeout_fail("ready_o stayed low for 50 cycles");
            end
            @(negedge clk);
        end
        tick();
        valid_i = 1'b0;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!valid_o) begin
            n++;
            if (n > 50) begin
                timeout_fail("valid_o did not rise within 50 cycles");
            end
            tick();
        end
    endtask

    task automatic wb_write(input logic [4:0] rd, input logic [63:0] data);
        wb_en_i   = 1'b1;
        wb_rd_i   = rd;
        wb_data_i = data;
        tick();
        wb_en_i = 1'b0;
        if (rd != 5'd0) begin
            exp_regs[rd] = data;
        end
    endtask

    task automatic imm_case(input logic [31:0] instr, input id_pkg::imm_fmt_e fmt,
                            input id_pkg::src1_sel_e s1, input id_pkg::src2_sel_e s2);
        logic [4:0] op;
        logic       writes;
        op     = instr[6:2];
        // stores and branches leave the register file alone
        writes = (op != id_pkg::OP_STORE) && (op != id_pkg::OP_BRANCH);
        send(instr, 64'h1000);
        wait_valid();
        check_eq("imm_o", imm_o, exp_imm(fmt, instr));
        check_eq("src1_sel_o", 64'(src1_sel_o), 64'(s1));
        check_eq("src2_sel_o", 64'(src2_sel_o), 64'(s2));
        check_eq("is_brc_o", 64'(is_brc_o), 64'(op == id_pkg::OP_BRANCH));
        check_eq("is_jal_o", 64'(is_jal_o), 64'(op == id_pkg::OP_JAL));
        check_eq("is_jalr_o", 64'(is_jalr_o), 64'(op == id_pkg::OP_JALR));
        check_eq("wb_en_o", 64'(wb_en_o), 64'(writes));
    endtask

    task automatic imm_formats();
        for (int i = 0; i < 6; i++) begin
            imm_case(rand_instr(id_pkg::OP_IMM), id_pkg::IMM_I, id_pkg::SRC1_RS1,
                     id_pkg::SRC2_IMM);
            imm_case(rand_instr(id_pkg::OP_STORE), id_pkg::IMM_S, id_pkg::SRC1_RS1,
                     id_pkg::SRC2_IMM);
            imm_case(rand_instr(id_pkg::OP_BRANCH), id_pkg::IMM_B, id_pkg::SRC1_RS1,
                     id_pkg::SRC2_RS2);
            imm_case(rand_instr(id_pkg::OP_LUI), id_pkg::IMM_U, id_pkg::SRC1_RS1,
                     id_pkg::SRC2_IMM);
            imm_case(rand_instr(id_pkg::OP_AUIPC), id_pkg::IMM_U, id_pkg::SRC1_PC,
                     id_pkg::SRC2_IMM);
            imm_case(rand_instr(id_pkg::OP_JAL), id_pkg::IMM_J, id_pkg::SRC1_PC,
                     id_pkg::SRC2_FOUR);
            imm_case(rand_instr(id_pkg::OP_JALR), id_pkg::IMM_I, id_pkg::SRC1_PC,
                     id_pkg::SRC2_FOUR);
        end
    endtask

    task automatic alu_decode_sweep();
        logic [4:0]  ops [4];
        logic [6:0]  f7s [3];
        logic [31:0] instr;
        logic        reg_op;
        ops = '{id_pkg::OP_REG, id_pkg::OP_REG_32, id_pkg::OP_IMM, id_pkg::OP_IMM_32};
        f7s = '{7'h00, 7'h20, 7'h01};
        for (int o = 0; o < 4; o++) begin
            for (int k = 0; k < 3; k++) begin
                for (int f3 = 0; f3 < 8; f3++) begin
                    instr = encode(f7s[k], 5'd2, 5'd1, 3'(f3), 5'd3, ops[o]);
                    send(instr, 64'h2000);
                    wait_valid();
                    check_eq("alu_op_o", 64'(alu_op_o),
                             64'(exp_alu(ops[o], 3'(f3), f7s[k])));
                    check_eq("wb_en_o", 64'(wb_en_o), 64'd1);
                    reg_op = (o < 2);
                    if (reg_op) begin
                        check_eq("div_en_o", 64'(div_en_o), 64'(f7s[k][0]));
                        if (f7s[k][0]) begin
                            check_eq("div_sel_o", 64'(div_sel_o), 64'(f3));
                        end
                    end
                end
            end
        end
    endtask

    task automatic reg_reads();
        logic [63:0] d;
        for (int r = 1; r < 8; r++) begin
            wb_write(5'(r), rand64());
        end
        for (int r = 1; r < 7; r++) begin
            send(encode(7'h00, 5'(r + 1), 5'(r), 3'd0, 5'd10, id_pkg::OP_REG), 64'h2100);
            wait_valid();
            check_eq("rs1_o", rs1_o, exp_regs[r]);
            check_eq("rs2_o", rs2_o, exp_regs[r + 1]);
        end
        // write and read of x9 in one cycle
        d         = rand64();
        wb_en_i   = 1'b1;
        wb_rd_i   = 5'd9;
        wb_data_i = d;
        send(encode(7'h00, 5'd1, 5'd9, 3'd0, 5'd10, id_pkg::OP_REG), 64'h2104);
        wb_en_i     = 1'b0;
        exp_regs[9] = d;
        wait_valid();
        check_eq("rs1_o", rs1_o, d);
        check_eq("rs2_o", rs2_o, exp_regs[1]);
        send(encode(7'h00, 5'd9, 5'd0, 3'd0, 5'd10, id_pkg::OP_REG), 64'h2108);
        wait_valid();
        check_eq("rs2_o", rs2_o, d);
        check_eq("rs1_o", rs1_o, 64'd0);
        // x0 ignores stored and bypassed writes
        wb_write(5'd0, rand64());
        wb_en_i   = 1'b1;
        wb_rd_i   = 5'd0;
        wb_data_i = rand64();
        send(encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd10, id_pkg::OP_REG), 64'h210c);
        wb_en_i = 1'b0;
        wait_valid();
        check_eq("rs1_o", rs1_o, 64'd0);
        check_eq("rs2_o", rs2_o, 64'd0);
    endtask

    task automatic load_use_stall();
        logic [63:0] ld_val;
        ld_val = rand64();
        send(encode(7'h00, 5'd8, 5'd1, 3'b011, 5'd5, id_pkg::OP_LOAD), 64'h3000);
        wait_valid();
        check_eq("is_load_o", 64'(is_load_o), 64'd1);
        // add x7, x5, x6 right behind the load
        valid_i = 1'b1;
        instr_i = encode(7'h00, 5'd6, 5'd5, 3'd0, 5'd7, id_pkg::OP_REG);
        pc_i    = 64'h3004;
        @(negedge clk);
        check_eq("ready_o", 64'(ready_o), 64'd0);
        tick();
        check_eq("valid_o", 64'(valid_o), 64'd0);
        // load result returns on the writeback port during the bubble
        wb_en_i   = 1'b1;
        wb_rd_i   = 5'd5;
        wb_data_i = ld_val;
        @(negedge clk);
        check_eq("ready_o", 64'(ready_o), 64'd1);
        tick();
        valid_i     = 1'b0;
        wb_en_i     = 1'b0;
        exp_regs[5] = ld_val;
        check_eq("valid_o", 64'(valid_o), 64'd1);
        check_eq("pc_o", pc_o, 64'h3004);
        check_eq("rs1_o", rs1_o, ld_val);
        check_eq("rs2_o", rs2_o, exp_regs[6]);
        // load to x0
        send(encode(7'h00, 5'd0, 5'd1, 3'b011, 5'd0, id_pkg::OP_LOAD), 64'h3008);
        wait_valid();
        valid_i = 1'b1;
        instr_i = encode(7'h00, 5'd6, 5'd0, 3'd0, 5'd7, id_pkg::OP_REG);
        pc_i    = 64'h300c;
        @(negedge clk);
        check_eq("ready_o", 64'(ready_o), 64'd1);
        tick();
        valid_i = 1'b0;
        check_eq("valid_o", 64'(valid_o), 64'd1);
        check_eq("pc_o", pc_o, 64'h300c);
        check_eq("rs1_o", rs1_o, 64'd0);
    endtask

    task automatic backpressure_hold();
        send(encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd11, id_pkg::OP_REG), 64'h4000);
        wait_valid();
        // execute stops taking the slot from here on
        ready_i = 1'b0;
        valid_i = 1'b1;
        instr_i = encode(7'h00, 5'd4, 5'd3, 3'd0, 5'd12, id_pkg::OP_REG);
        pc_i    = 64'h4004;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_eq("ready_o", 64'(ready_o), 64'd0);
            check_eq("valid_o", 64'(valid_o), 64'd1);
            check_eq("pc_o", pc_o, 64'h4000);
            check_eq("rs1_o", rs1_o, exp_regs[1]);
            check_eq("rs2_o", rs2_o, exp_regs[2]);
            check_eq("rd_o", 64'(rd_o), 64'd11);
            tick();
        end
        ready_i = 1'b1;
        send(encode(7'h00, 5'd4, 5'd3, 3'd0, 5'd12, id_pkg::OP_REG), 64'h4004);
        wait_valid();
        check_eq("pc_o", pc_o, 64'h4004);
        check_eq("rs1_o", rs1_o, exp_regs[3]);
        check_eq("rd_o", 64'(rd_o), 64'd12);
    endtask

    task automatic trap_case(input logic [31:0] instr, input logic t_in, input logic t_out);
        send(instr, 64'h5000);
        wait_valid();
        check_eq("trap_o", 64'(trap_o), 64'd1);
        check_eq("trap_in_o", 64'(trap_in_o), 64'(t_in));
        check_eq("trap_out_o", 64'(trap_out_o), 64'(t_out));
        check_eq("wb_en_o", 64'(wb_en_o), 64'd0);
    endtask

    task automatic trap_decode();
        // ecall, ebreak, mret
        trap_case(32'h00000073, 1'b1, 1'b0);
        trap_case(32'h00100073, 1'b1, 1'b0);
        trap_case(32'h30200073, 1'b0, 1'b1);
    endtask

    initial begin
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        pc_i      = '0;
        instr_i   = 32'h00000013;
        wb_en_i   = 1'b0;
        wb_rd_i   = '0;
        wb_data_i = '0;
        ready_i   = 1'b1;
        for (int r = 0; r < 32; r++) begin
            exp_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_eq("valid_o", 64'(valid_o), 64'd0);
        check_eq("ready_o", 64'(ready_o), 64'd1);
        tick();
        imm_formats();
        alu_decode_sweep();
        reg_reads();
        load_use_stall();
        backpressure_hold();
        trap_decode();
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* src/id_stage.sv */
module id_stage (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    output logic                        ready_o,
    input  logic [id_pkg::XLEN-1:0]     pc_i,
    input  logic [id_pkg::INST_LEN-1:0] instr_i,
    input  logic                        wb_en_i,
    input  logic [4:0]                  wb_rd_i,
    input  logic [id_pkg::XLEN-1:0]     wb_data_i,
    input  logic                        ready_i,
    output logic                        valid_o,
    output logic [id_pkg::XLEN-1:0]     pc_o,
    output logic [id_pkg::XLEN-1:0]     rs1_o,
    output logic [id_pkg::XLEN-1:0]     rs2_o,
    output logic [id_pkg::XLEN-1:0]     imm_o,
    output id_pkg::alu_op_e             alu_op_o,
    output id_pkg::src1_sel_e           src1_sel_o,
    output id_pkg::src2_sel_e           src2_sel_o,
    output logic [4:0]                  rd_o,
    output logic                        wb_en_o,
    output logic                        is_load_o,
    output logic                        is_jal_o,
    output logic                        is_jalr_o,
    output logic                        is_brc_o,
    output logic                        div_en_o,
    output logic [2:0]                  div_sel_o,
    output logic                        trap_o,
    output logic                        trap_in_o,
    output logic                        trap_out_o
);

    logic [id_pkg::XLEN-1:0] rs1_data;
    logic [id_pkg::XLEN-1:0] rs2_data;

    id_ctrl_if u_ctrl_if ();

    instr_decoder u_decoder (
        .instr_i (id_pkg::instr_u'(instr_i)),
        .ctrl    (u_ctrl_if.dec)
    );

    // reads are indexed straight from the decoder
    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (u_ctrl_if.rs1_idx),
        .rs2_addr_i (u_ctrl_if.rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_addr_i  (wb_rd_i),
        .wr_data_i  (wb_data_i),
        .wr_en_i    (wb_en_i)
    );

    id_ex_reg u_id_ex_reg (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .ready_o    (ready_o),
        .pc_i       (pc_i),
        .ctrl       (u_ctrl_if.slot),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ready_i    (ready_i),
        .valid_o    (valid_o),
        .pc_o       (pc_o),
        .rs1_o      (rs1_o),
        .rs2_o      (rs2_o),
        .imm_o      (imm_o),
        .alu_op_o   (alu_op_o),
        .src1_sel_o (src1_sel_o),
        .src2_sel_o (src2_sel_o),
        .rd_o       (rd_o),
        .wb_en_o    (wb_en_o),
        .is_load_o  (is_load_o),
        .is_jal_o   (is_jal_o),
        .is_jalr_o  (is_jalr_o),
        .is_brc_o   (is_brc_o),
        .div_en_o   (div_en_o),
        .div_sel_o  (div_sel_o),
        .trap_o     (trap_o),
        .trap_in_o  (trap_in_o),
        .trap_out_o (trap_out_o)
    );

endmodule

/* src/id_ex_reg.sv */
module id_ex_reg (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    output logic                    ready_o,
    input  logic [id_pkg::XLEN-1:0] pc_i,
    id_ctrl_if.slot                 ctrl,
    input  logic [id_pkg::XLEN-1:0] rs1_data_i,
    input  logic [id_pkg::XLEN-1:0] rs2_data_i,
    input  logic                    ready_i,
    output logic                    valid_o,
    output logic [id_pkg::XLEN-1:0] pc_o,
    output logic [id_pkg::XLEN-1:0] rs1_o,
    output logic [id_pkg::XLEN-1:0] rs2_o,
    output logic [id_pkg::XLEN-1:0] imm_o,
    output id_pkg::alu_op_e         alu_op_o,
    output id_pkg::src1_sel_e       src1_sel_o,
    output id_pkg::src2_sel_e       src2_sel_o,
    output logic [4:0]              rd_o,
    output logic                    wb_en_o,
    output logic                    is_load_o,
    output logic                    is_jal_o,
    output logic                    is_jalr_o,
    output logic                    is_brc_o,
    output logic                    div_en_o,
    output logic [2:0]              div_sel_o,
    output logic                    trap_o,
    output logic                    trap_in_o,
    output logic                    trap_out_o
);

    logic hazard;
    logic slot_free;
    logic accept;

    // held load feeds a register the incoming instruction reads
    assign hazard = valid_o && is_load_o && (rd_o != 5'd0) &&
                    ((rd_o == ctrl.rs1_idx) || (rd_o == ctrl.rs2_idx));

    // empty now or emptied at this edge
    assign slot_free = !valid_o || ready_i;
    assign ready_o   = slot_free && !hazard;
    assign accept    = valid_i && ready_o;

    // a free slot with a hazard takes a bubble
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (slot_free) begin
            valid_o <= valid_i && !hazard;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_o       <= pc_i;
            rs1_o      <= rs1_data_i;
            rs2_o      <= rs2_data_i;
            imm_o      <= ctrl.imm;
            alu_op_o   <= ctrl.alu_op;
            src1_sel_o <= ctrl.src1_sel;
            src2_sel_o <= ctrl.src2_sel;
            rd_o       <= ctrl.rd_idx;
            wb_en_o    <= ctrl.wb_en;
            is_load_o  <= ctrl.is_load;
            is_jal_o   <= ctrl.is_jal;
            is_jalr_o  <= ctrl.is_jalr;
            is_brc_o   <= ctrl.is_brc;
            div_en_o   <= ctrl.div_en;
            div_sel_o  <= ctrl.div_sel;
            trap_o     <= ctrl.trap;
            trap_in_o  <= ctrl.trap_in;
            trap_out_o <= ctrl.trap_out;
        end
    end

endmodule

/* src/reg_file.sv */
module reg_file (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [4:0]              rs1_addr_i,
    input  logic [4:0]              rs2_addr_i,
    output logic [id_pkg::XLEN-1:0] rs1_data_o,
    output logic [id_pkg::XLEN-1:0] rs2_data_o,
    input  logic [4:0]              wr_addr_i,
    input  logic [id_pkg::XLEN-1:0] wr_data_i,
    input  logic                    wr_en_i
);

    logic [id_pkg::XLEN-1:0] regs [id_pkg::REG_NUM];
    logic                    wr_live;

    // x0 is never written
    assign wr_live = wr_en_i && (wr_addr_i != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < id_pkg::REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // writeback data in the same cycle wins over the array
    always_comb begin
        if (wr_live && (wr_addr_i == rs1_addr_i)) begin
            rs1_data_o = wr_data_i;
        end else begin
            rs1_data_o = regs[rs1_addr_i];
        end
    end

    always_comb begin
        if (wr_live && (wr_addr_i == rs2_addr_i)) begin
            rs2_data_o = wr_data_i;
        end else begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

/* src/instr_decoder.sv */
module instr_decoder (
    input  id_pkg::instr_u instr_i,
    id_ctrl_if.dec         ctrl
);

    logic [4:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             word_op;
    id_pkg::imm_fmt_e imm_fmt;

    assign opcode  = instr_i.rtype.opcode[6:2];
    assign funct3  = instr_i.rtype.funct3;
    assign funct7  = instr_i.rtype.funct7;
    // opcode bit 1 marks the 32-bit word groups
    assign word_op = opcode[1];

    function automatic id_pkg::alu_op_e alu_decode(
        input logic [2:0] f3,
        input logic       alt_sub,
        input logic       alt_sra,
        input logic       word
    );
        id_pkg::alu_op_e op;
        case (f3)
            id_pkg::F3_ADD: begin
                if (alt_sub) begin
                    op = word ? id_pkg::ALU_SUBW : id_pkg::ALU_SUB;
                end else begin
                    op = word ? id_pkg::ALU_ADDW : id_pkg::ALU_ADD;
                end
            end
            id_pkg::F3_SLL:  op = word ? id_pkg::ALU_SLLW : id_pkg::ALU_SLL;
            id_pkg::F3_SLT:  op = id_pkg::ALU_SLT;
            id_pkg::F3_SLTU: op = id_pkg::ALU_SLTU;
            id_pkg::F3_XOR:  op = id_pkg::ALU_XOR;
            id_pkg::F3_SR: begin
                if (alt_sra) begin
                    op = word ? id_pkg::ALU_SRAW : id_pkg::ALU_SRA;
                end else begin
                    op = word ? id_pkg::ALU_SRLW : id_pkg::ALU_SRL;
                end
            end
            id_pkg::F3_OR:   op = id_pkg::ALU_OR;
            default:         op = id_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // defaults describe a bundle that does nothing
        ctrl.alu_op   = id_pkg::ALU_ADD;
        ctrl.src1_sel = id_pkg::SRC1_RS1;
        ctrl.src2_sel = id_pkg::SRC2_RS2;
        ctrl.rs1_idx  = 5'd0;
        ctrl.rs2_idx  = 5'd0;
        ctrl.rd_idx   = 5'd0;
        ctrl.wb_en    = 1'b0;
        ctrl.is_load  = 1'b0;
        ctrl.is_jal   = 1'b0;
        ctrl.is_jalr  = 1'b0;
        ctrl.is_brc   = 1'b0;
        ctrl.div_en   = 1'b0;
        ctrl.div_sel  = 3'd0;
        ctrl.trap     = 1'b0;
        ctrl.trap_in  = 1'b0;
        ctrl.trap_out = 1'b0;
        imm_fmt       = id_pkg::IMM_NONE;

        case (opcode)
            id_pkg::OP_REG, id_pkg::OP_REG_32: begin
                ctrl.alu_op  = alu_decode(funct3, funct7[5], funct7[5], word_op);
                ctrl.rs1_idx = instr_i.rtype.rs1;
                ctrl.rs2_idx = instr_i.rtype.rs2;
                ctrl.rd_idx  = instr_i.rtype.rd;
                ctrl.wb_en   = 1'b1;
                // M extension rides on funct7 bit 0
                ctrl.div_en  = funct7[0];
                ctrl.div_sel = funct3;
            end
            id_pkg::OP_IMM, id_pkg::OP_IMM_32: begin
                // no subtract form for immediates
                ctrl.alu_op   = alu_decode(funct3, 1'b0, funct7[5], word_op);
                ctrl.src2_sel = id_pkg::SRC2_IMM;
                ctrl.rs1_idx  = instr_i.rtype.rs1;
                ctrl.rd_idx   = instr_i.rtype.rd;
                ctrl.wb_en    = 1'b1;
                imm_fmt       = id_pkg::IMM_I;
            end
            id_pkg::OP_LOAD: begin
                ctrl.src2_sel = id_pkg::SRC2_IMM;
                ctrl.rs1_idx  = instr_i.rtype.rs1;
                ctrl.rd_idx   = instr_i.rtype.rd;
                ctrl.wb_en    = 1'b1;
                ctrl.is_load  = 1'b1;
                imm_fmt       = id_pkg::IMM_I;
            end
            id_pkg::OP_STORE: begin
                ctrl.src2_sel = id_pkg::SRC2_IMM;
                ctrl.rs1_idx  = instr_i.rtype.rs1;
                ctrl.rs2_idx  = instr_i.rtype.rs2;
                imm_fmt       = id_pkg::IMM_S;
            end
            id_pkg::OP_BRANCH: begin
                ctrl.rs1_idx = instr_i.rtype.rs1;
                ctrl.rs2_idx = instr_i.rtype.rs2;
                ctrl.is_brc  = 1'b1;
                imm_fmt      = id_pkg::IMM_B;
            end
            id_pkg::OP_JAL: begin
                // link value is pc + 4
                ctrl.src1_sel = id_pkg::SRC1_PC;
                ctrl.src2_sel = id_pkg::SRC2_FOUR;
                ctrl.rd_idx   = instr_i.ujtype.rd;
                ctrl.wb_en    = 1'b1;
                ctrl.is_jal   = 1'b1;
                imm_fmt       = id_pkg::IMM_J;
            end
            id_pkg::OP_JALR: begin
                ctrl.src1_sel = id_pkg::SRC1_PC;
                ctrl.src2_sel = id_pkg::SRC2_FOUR;
                ctrl.rs1_idx  = instr_i.rtype.rs1;
                ctrl.rd_idx   = instr_i.rtype.rd;
                ctrl.wb_en    = 1'b1;
                ctrl.is_jalr  = 1'b1;
                imm_fmt       = id_pkg::IMM_I;
            end
            id_pkg::OP_LUI: begin
                ctrl.alu_op   = id_pkg::ALU_SRC2;
                ctrl.src2_sel = id_pkg::SRC2_IMM;
                ctrl.rd_idx   = instr_i.ujtype.rd;
                ctrl.wb_en    = 1'b1;
                imm_fmt       = id_pkg::IMM_U;
            end
            id_pkg::OP_AUIPC: begin
                ctrl.src1_sel = id_pkg::SRC1_PC;
                ctrl.src2_sel = id_pkg::SRC2_IMM;
                ctrl.rd_idx   = instr_i.ujtype.rd;
                ctrl.wb_en    = 1'b1;
                imm_fmt       = id_pkg::IMM_U;
            end
            id_pkg::OP_SYSTEM: begin
                ctrl.src2_sel = id_pkg::SRC2_ZERO;
                // csr forms are handled elsewhere
                if (funct3 == id_pkg::F3_ENV) begin
                    ctrl.trap = 1'b1;
                    // rs2 field: 0 ecall, 1 ebreak, 2 mret
                    if (instr_i.rtype.rs2[1]) begin
                        ctrl.trap_out = 1'b1;
                    end else begin
                        ctrl.trap_in = 1'b1;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    // sign extension per format
    always_comb begin
        case (imm_fmt)
            id_pkg::IMM_I: ctrl.imm = {{52{funct7[6]}}, funct7, instr_i.rtype.rs2};
            id_pkg::IMM_S: ctrl.imm = {{52{funct7[6]}}, funct7, instr_i.rtype.rd};
            id_pkg::IMM_B: ctrl.imm = {{52{funct7[6]}}, instr_i.rtype.rd[0], funct7[5:0],
                                       instr_i.rtype.rd[4:1], 1'b0};
            id_pkg::IMM_U: ctrl.imm = {{32{instr_i.ujtype.imm_hi[19]}},
                                       instr_i.ujtype.imm_hi, 12'h000};
            id_pkg::IMM_J: ctrl.imm = {{44{instr_i.ujtype.imm_hi[19]}},
                                       instr_i.ujtype.imm_hi[7:0],
                                       instr_i.ujtype.imm_hi[8],
                                       instr_i.ujtype.imm_hi[18:9], 1'b0};
            default:       ctrl.imm = '0;
        endcase
    end

endmodule

/* src/id_ctrl_if.sv */
interface id_ctrl_if;

    id_pkg::alu_op_e   alu_op;
    id_pkg::src1_sel_e src1_sel;
    id_pkg::src2_sel_e src2_sel;
    logic [id_pkg::XLEN-1:0] imm;
    // source indices read as zero when the source is unused
    logic [4:0] rs1_idx;
    logic [4:0] rs2_idx;
    logic [4:0] rd_idx;
    logic       wb_en;
    logic       is_load;
    logic       is_jal;
    logic       is_jalr;
    logic       is_brc;
    // multiply/divide unit select
    logic       div_en;
    logic [2:0] div_sel;
    logic       trap;
    logic       trap_in;
    logic       trap_out;

    modport dec (
        output alu_op, src1_sel, src2_sel, imm,
        output rs1_idx, rs2_idx, rd_idx,
        output wb_en, is_load, is_jal, is_jalr, is_brc,
        output div_en, div_sel, trap, trap_in, trap_out
    );

    modport slot (
        input alu_op, src1_sel, src2_sel, imm,
        input rs1_idx, rs2_idx, rd_idx,
        input wb_en, is_load, is_jal, is_jalr, is_brc,
        input div_en, div_sel, trap, trap_in, trap_out
    );

endinterface

/* src/id_pkg.sv */
package id_pkg;

    // datapath widths
    localparam int XLEN     = 64;
    localparam int INST_LEN = 32;
    localparam int REG_NUM  = 32;

    // major opcodes, instruction bits 6 to 2
    localparam logic [4:0] OP_LOAD   = 5'b00000;
    localparam logic [4:0] OP_IMM    = 5'b00100;
    localparam logic [4:0] OP_AUIPC  = 5'b00101;
    localparam logic [4:0] OP_IMM_32 = 5'b00110;
    localparam logic [4:0] OP_STORE  = 5'b01000;
    localparam logic [4:0] OP_REG    = 5'b01100;
    localparam logic [4:0] OP_LUI    = 5'b01101;
    localparam logic [4:0] OP_REG_32 = 5'b01110;
    localparam logic [4:0] OP_BRANCH = 5'b11000;
    localparam logic [4:0] OP_JALR   = 5'b11001;
    localparam logic [4:0] OP_JAL    = 5'b11011;
    localparam logic [4:0] OP_SYSTEM = 5'b11100;

    // funct3 values shared by the register and immediate groups
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    // ecall, ebreak and mret share this one
    localparam logic [2:0] F3_ENV  = 3'b000;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_SLL  = 5'd2,
        ALU_SRL  = 5'd3,
        ALU_SRA  = 5'd4,
        ALU_ADDW = 5'd5,
        ALU_SUBW = 5'd6,
        ALU_SLLW = 5'd7,
        ALU_SRLW = 5'd8,
        ALU_SRAW = 5'd9,
        ALU_SLT  = 5'd10,
        ALU_SLTU = 5'd11,
        ALU_XOR  = 5'd12,
        ALU_OR   = 5'd13,
        ALU_AND  = 5'd14,
        ALU_SRC2 = 5'd15
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    typedef enum logic {
        SRC1_RS1 = 1'b0,
        SRC1_PC  = 1'b1
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RS2   = 2'd0,
        SRC2_IMM   = 2'd1,
        SRC2_FOUR  = 2'd2,
        SRC2_ZERO  = 2'd3
    } src2_sel_e;

    // R/I/S slicing of the instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // U/J slicing, upper 20 bits as one field
    typedef struct packed {
        logic [19:0] imm_hi;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_uj_t;

    typedef union packed {
        instr_r_t  rtype;
        instr_uj_t ujtype;
    } instr_u;

endpackage
